// ==== include/tomasulo_cfg.svh ====
`ifndef TOMASULO_CFG_SVH
`define TOMASULO_CFG_SVH

// Data path width
`define XLEN 32

// Architectural registers, x0 reads as zero
`define REG_COUNT 32

// Station entries per functional-unit class
`define RS_ALU_ENTRIES 2
`define RS_MUL_ENTRIES 2

// Multiplier pipeline depth in cycles
`define MUL_LATENCY 3

`endif

// ==== source/tomasulo_pkg.sv ====
`default_nettype none

package tomasulo_pkg;

    // Entry tag, 0 means the value is ready
    typedef logic [2:0] rs_tag_t;

    typedef enum logic {
        fu_alu,
        fu_mul
    } fu_class_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_slt
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // One instruction word seen as R-type or as I-type
    typedef union packed {
        r_type_t r_view;
        i_type_t i_view;
    } instr_word_u;

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

endpackage

`default_nettype wire

// ==== source/dispatch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tomasulo_cfg.svh"

module dispatch_stage
    import tomasulo_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic             instr_valid,
    output logic             instr_ready,
    input  instr_word_u      instr,
    output logic             alloc_valid,
    output fu_class_e        alloc_class,
    output alu_op_e          alloc_op,
    output rs_tag_t          alloc_t1,
    output rs_tag_t          alloc_t2,
    output logic [`XLEN-1:0] alloc_v1,
    output logic [`XLEN-1:0] alloc_v2,
    output logic [4:0]       alloc_rd,
    input  logic             alloc_ready,
    input  rs_tag_t          alloc_tag,
    input  logic             cdb_valid,
    input  rs_tag_t          cdb_tag,
    input  logic [`XLEN-1:0] cdb_value,
    output logic [4:0]       cdb_rd,
    input  logic [4:0]       debug_index,
    output logic [`XLEN-1:0] debug_value
);

    localparam int NUM_TAGS = `RS_ALU_ENTRIES + `RS_MUL_ENTRIES + 1;

    logic [`XLEN-1:0] regs [`REG_COUNT];
    rs_tag_t          map_tag [`REG_COUNT];
    logic [4:0]       tag_rd [NUM_TAGS];
    logic             is_op;
    logic             is_op_imm;
    logic             is_mul;
    logic             legal;
    logic             accept;
    logic [`XLEN-1:0] imm_ext;

    // Producer tag of a source, cleared when that producer is on the CDB now
    function automatic rs_tag_t src_tag(input logic [4:0] idx);
        if (cdb_valid && map_tag[idx] != '0 && cdb_tag == map_tag[idx])
            return '0;
        return map_tag[idx];
    endfunction

    function automatic logic [`XLEN-1:0] src_value(input logic [4:0] idx);
        if (map_tag[idx] == '0)
            return regs[idx];
        if (cdb_valid && cdb_tag == map_tag[idx])
            return cdb_value;
        return '0;
    endfunction

    assign is_op     = instr.r_view.opcode == OPCODE_OP;
    assign is_op_imm = instr.i_view.opcode == OPCODE_OP_IMM;
    assign imm_ext   = {{(`XLEN-12){instr.i_view.imm12[11]}}, instr.i_view.imm12};

    always_comb begin
        is_mul   = 1'b0;
        alloc_op = alu_add;
        legal    = is_op || is_op_imm;
        if (is_op && instr.r_view.funct7 == 7'b0000001) begin
            // Only MUL of the M extension is executed
            is_mul = 1'b1;
            legal  = instr.r_view.funct3 == 3'b000;
        end else begin
            case (instr.r_view.funct3)
                3'b000:  alloc_op = (is_op && instr.r_view.funct7[5]) ? alu_sub : alu_add;
                3'b001:  alloc_op = alu_sll;
                3'b010:  alloc_op = alu_slt;
                3'b100:  alloc_op = alu_xor;
                3'b101:  alloc_op = alu_srl;
                3'b110:  alloc_op = alu_or;
                3'b111:  alloc_op = alu_and;
                default: legal = 1'b0;
            endcase
        end
    end

    // Operand read with CDB bypass, immediate goes in the second slot
    always_comb begin
        alloc_t1 = src_tag(instr.i_view.rs1);
        alloc_v1 = src_value(instr.i_view.rs1);
        if (is_op_imm) begin
            alloc_t2 = '0;
            alloc_v2 = imm_ext;
        end else begin
            alloc_t2 = src_tag(instr.r_view.rs2);
            alloc_v2 = src_value(instr.r_view.rs2);
        end
    end

    assign alloc_class = is_mul ? fu_mul : fu_alu;
    assign alloc_rd    = instr.r_view.rd;
    assign alloc_valid = instr_valid && legal;
    // Dropped opcodes are always taken
    assign instr_ready = legal ? alloc_ready : 1'b1;
    assign accept      = alloc_valid && alloc_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                regs[r]    <= '0;
                map_tag[r] <= '0;
            end
        end else begin
            // Write back only if this tag is still the latest producer
            for (int r = 1; r < `REG_COUNT; r++) begin
                if (cdb_valid && map_tag[r] != '0 && map_tag[r] == cdb_tag) begin
                    regs[r]    <= cdb_value;
                    map_tag[r] <= '0;
                end
            end
            if (accept && alloc_rd != '0)
                map_tag[alloc_rd] <= alloc_tag;
        end
    end

    always_ff @(posedge clock) begin
        if (accept)
            tag_rd[alloc_tag] <= alloc_rd;
    end

    assign cdb_rd      = cdb_valid ? tag_rd[cdb_tag] : '0;
    assign debug_value = regs[debug_index];

endmodule

`default_nettype wire

// ==== source/reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tomasulo_cfg.svh"

module reservation_station
    import tomasulo_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic             alloc_valid,
    input  fu_class_e        alloc_class,
    input  alu_op_e          alloc_op,
    input  rs_tag_t          alloc_t1,
    input  rs_tag_t          alloc_t2,
    input  logic [`XLEN-1:0] alloc_v1,
    input  logic [`XLEN-1:0] alloc_v2,
    output logic             alloc_ready,
    output rs_tag_t          alloc_tag,
    input  logic             cdb_valid,
    input  rs_tag_t          cdb_tag,
    input  logic [`XLEN-1:0] cdb_value,
    output logic             alu_issue_valid,
    input  logic             alu_issue_ready,
    output rs_tag_t          alu_issue_tag,
    output alu_op_e          alu_issue_op,
    output logic [`XLEN-1:0] alu_issue_a,
    output logic [`XLEN-1:0] alu_issue_b,
    output logic             mul_issue_valid,
    input  logic             mul_issue_ready,
    output rs_tag_t          mul_issue_tag,
    output logic [`XLEN-1:0] mul_issue_a,
    output logic [`XLEN-1:0] mul_issue_b,
    output logic             rs_busy
);

    // Slot 0 is the ready tag and never holds an entry
    localparam int NUM_TAGS = `RS_ALU_ENTRIES + `RS_MUL_ENTRIES + 1;

    logic             busy [NUM_TAGS];
    logic             issued [NUM_TAGS];
    alu_op_e          op [NUM_TAGS];
    rs_tag_t          t1 [NUM_TAGS];
    rs_tag_t          t2 [NUM_TAGS];
    logic [`XLEN-1:0] v1 [NUM_TAGS];
    logic [`XLEN-1:0] v2 [NUM_TAGS];
    rs_tag_t          alu_sel;
    rs_tag_t          mul_sel;
    logic             alloc_fire;

    // Class is fixed by the tag range
    function automatic fu_class_e class_of(input int tag);
        return (tag <= `RS_ALU_ENTRIES) ? fu_alu : fu_mul;
    endfunction

    // Lowest free tag of the requested class
    always_comb begin
        alloc_ready = 1'b0;
        alloc_tag   = '0;
        for (int i = NUM_TAGS - 1; i >= 1; i--) begin
            if (!busy[i] && class_of(i) == alloc_class) begin
                alloc_ready = 1'b1;
                alloc_tag   = rs_tag_t'(i);
            end
        end
    end

    assign alloc_fire = alloc_valid && alloc_ready;

    // Oldest-first here means lowest ready tag per class
    always_comb begin
        alu_issue_valid = 1'b0;
        mul_issue_valid = 1'b0;
        alu_sel         = rs_tag_t'(1);
        mul_sel         = rs_tag_t'(`RS_ALU_ENTRIES + 1);
        for (int i = NUM_TAGS - 1; i >= 1; i--) begin
            if (busy[i] && !issued[i] && t1[i] == '0 && t2[i] == '0) begin
                if (class_of(i) == fu_alu) begin
                    alu_issue_valid = 1'b1;
                    alu_sel         = rs_tag_t'(i);
                end else begin
                    mul_issue_valid = 1'b1;
                    mul_sel         = rs_tag_t'(i);
                end
            end
        end
    end

    assign alu_issue_tag = alu_sel;
    assign alu_issue_op  = op[alu_sel];
    assign alu_issue_a   = v1[alu_sel];
    assign alu_issue_b   = v2[alu_sel];
    assign mul_issue_tag = mul_sel;
    assign mul_issue_a   = v1[mul_sel];
    assign mul_issue_b   = v2[mul_sel];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_TAGS; i++) begin
                busy[i]   <= 1'b0;
                issued[i] <= 1'b0;
            end
        end else begin
            for (int i = 1; i < NUM_TAGS; i++) begin
                if (cdb_valid && cdb_tag == rs_tag_t'(i)) begin
                    busy[i]   <= 1'b0;
                    issued[i] <= 1'b0;
                end else if (alloc_fire && alloc_tag == rs_tag_t'(i)) begin
                    busy[i]   <= 1'b1;
                    issued[i] <= 1'b0;
                end else if ((alu_issue_valid && alu_issue_ready && alu_sel == rs_tag_t'(i))
                          || (mul_issue_valid && mul_issue_ready && mul_sel == rs_tag_t'(i))) begin
                    issued[i] <= 1'b1;
                end
            end
        end
    end

    // Operand fields: fill on allocation, capture CDB values while waiting
    always_ff @(posedge clock) begin
        for (int i = 1; i < NUM_TAGS; i++) begin
            if (alloc_fire && alloc_tag == rs_tag_t'(i)) begin
                op[i] <= alloc_op;
                t1[i] <= alloc_t1;
                t2[i] <= alloc_t2;
                v1[i] <= alloc_v1;
                v2[i] <= alloc_v2;
            end else begin
                if (cdb_valid && t1[i] != '0 && t1[i] == cdb_tag) begin
                    t1[i] <= '0;
                    v1[i] <= cdb_value;
                end
                if (cdb_valid && t2[i] != '0 && t2[i] == cdb_tag) begin
                    t2[i] <= '0;
                    v2[i] <= cdb_value;
                end
            end
        end
    end

    always_comb begin
        rs_busy = 1'b0;
        for (int i = 1; i < NUM_TAGS; i++)
            rs_busy = rs_busy | busy[i];
    end

endmodule

`default_nettype wire

// ==== source/execute_units.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tomasulo_cfg.svh"

module execute_units
    import tomasulo_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic             alu_issue_valid,
    output logic             alu_issue_ready,
    input  rs_tag_t          alu_issue_tag,
    input  alu_op_e          alu_issue_op,
    input  logic [`XLEN-1:0] alu_issue_a,
    input  logic [`XLEN-1:0] alu_issue_b,
    input  logic             mul_issue_valid,
    output logic             mul_issue_ready,
    input  rs_tag_t          mul_issue_tag,
    input  logic [`XLEN-1:0] mul_issue_a,
    input  logic [`XLEN-1:0] mul_issue_b,
    output logic             cdb_valid,
    output rs_tag_t          cdb_tag,
    output logic [`XLEN-1:0] cdb_value
);

    localparam int LAST = `MUL_LATENCY - 1;

    logic             alu_valid;
    rs_tag_t          alu_tag;
    logic [`XLEN-1:0] alu_value;
    logic [`XLEN-1:0] alu_result;
    logic             mul_valid [`MUL_LATENCY];
    rs_tag_t          mul_tag [`MUL_LATENCY];
    logic [`XLEN-1:0] mul_value [`MUL_LATENCY];
    logic             mul_done;

    always_comb begin
        case (alu_issue_op)
            alu_add: alu_result = alu_issue_a + alu_issue_b;
            alu_sub: alu_result = alu_issue_a - alu_issue_b;
            alu_and: alu_result = alu_issue_a & alu_issue_b;
            alu_or:  alu_result = alu_issue_a | alu_issue_b;
            alu_xor: alu_result = alu_issue_a ^ alu_issue_b;
            alu_sll: alu_result = alu_issue_a << alu_issue_b[4:0];
            alu_srl: alu_result = alu_issue_a >> alu_issue_b[4:0];
            alu_slt: alu_result = {{(`XLEN-1){1'b0}},
                                   $signed(alu_issue_a) < $signed(alu_issue_b)};
            default: alu_result = '0;
        endcase
    end

    // Multiplier owns the CDB whenever its last stage is full
    assign mul_done        = mul_valid[LAST];
    assign alu_issue_ready = !alu_valid || !mul_done;
    assign mul_issue_ready = 1'b1;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            alu_valid <= 1'b0;
        else if (alu_issue_valid && alu_issue_ready)
            alu_valid <= 1'b1;
        else if (!mul_done)
            alu_valid <= 1'b0;
    end

    always_ff @(posedge clock) begin
        if (alu_issue_valid && alu_issue_ready) begin
            alu_tag   <= alu_issue_tag;
            alu_value <= alu_result;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < `MUL_LATENCY; s++)
                mul_valid[s] <= 1'b0;
        end else begin
            mul_valid[0] <= mul_issue_valid && mul_issue_ready;
            for (int s = 1; s < `MUL_LATENCY; s++)
                mul_valid[s] <= mul_valid[s-1];
        end
    end

    // Low word of the product, then carried down the pipe
    always_ff @(posedge clock) begin
        mul_tag[0]   <= mul_issue_tag;
        mul_value[0] <= mul_issue_a * mul_issue_b;
        for (int s = 1; s < `MUL_LATENCY; s++) begin
            mul_tag[s]   <= mul_tag[s-1];
            mul_value[s] <= mul_value[s-1];
        end
    end

    assign cdb_valid = mul_done || alu_valid;
    assign cdb_tag   = mul_done ? mul_tag[LAST] : alu_tag;
    assign cdb_value = mul_done ? mul_value[LAST] : alu_value;

endmodule

`default_nettype wire

// ==== source/tomasulo_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tomasulo_cfg.svh"

module tomasulo_core
    import tomasulo_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  logic             instr_valid,
    output logic             instr_ready,
    input  instr_word_u      instr,
    output logic             cdb_valid,
    output logic [4:0]       cdb_rd,
    output logic [`XLEN-1:0] cdb_value,
    input  logic [4:0]       debug_index,
    output logic [`XLEN-1:0] debug_value,
    output logic             rs_busy
);

    logic             alloc_valid;
    fu_class_e        alloc_class;
    alu_op_e          alloc_op;
    rs_tag_t          alloc_t1;
    rs_tag_t          alloc_t2;
    logic [`XLEN-1:0] alloc_v1;
    logic [`XLEN-1:0] alloc_v2;
    logic             alloc_ready;
    rs_tag_t          alloc_tag;
    rs_tag_t          cdb_tag;
    logic             alu_issue_valid;
    logic             alu_issue_ready;
    rs_tag_t          alu_issue_tag;
    alu_op_e          alu_issue_op;
    logic [`XLEN-1:0] alu_issue_a;
    logic [`XLEN-1:0] alu_issue_b;
    logic             mul_issue_valid;
    logic             mul_issue_ready;
    rs_tag_t          mul_issue_tag;
    logic [`XLEN-1:0] mul_issue_a;
    logic [`XLEN-1:0] mul_issue_b;

    // Destination per tag is kept in dispatch, so alloc_rd stays local to it
    dispatch_stage u_dispatch (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .alloc_valid (alloc_valid),
        .alloc_class (alloc_class),
        .alloc_op    (alloc_op),
        .alloc_t1    (alloc_t1),
        .alloc_t2    (alloc_t2),
        .alloc_v1    (alloc_v1),
        .alloc_v2    (alloc_v2),
        .alloc_rd    (),
        .alloc_ready (alloc_ready),
        .alloc_tag   (alloc_tag),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value),
        .cdb_rd      (cdb_rd),
        .debug_index (debug_index),
        .debug_value (debug_value)
    );

    reservation_station u_station (
        .clock           (clock),
        .reset           (reset),
        .alloc_valid     (alloc_valid),
        .alloc_class     (alloc_class),
        .alloc_op        (alloc_op),
        .alloc_t1        (alloc_t1),
        .alloc_t2        (alloc_t2),
        .alloc_v1        (alloc_v1),
        .alloc_v2        (alloc_v2),
        .alloc_ready     (alloc_ready),
        .alloc_tag       (alloc_tag),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value),
        .alu_issue_valid (alu_issue_valid),
        .alu_issue_ready (alu_issue_ready),
        .alu_issue_tag   (alu_issue_tag),
        .alu_issue_op    (alu_issue_op),
        .alu_issue_a     (alu_issue_a),
        .alu_issue_b     (alu_issue_b),
        .mul_issue_valid (mul_issue_valid),
        .mul_issue_ready (mul_issue_ready),
        .mul_issue_tag   (mul_issue_tag),
        .mul_issue_a     (mul_issue_a),
        .mul_issue_b     (mul_issue_b),
        .rs_busy         (rs_busy)
    );

    execute_units u_execute (
        .clock           (clock),
        .reset           (reset),
        .alu_issue_valid (alu_issue_valid),
        .alu_issue_ready (alu_issue_ready),
        .alu_issue_tag   (alu_issue_tag),
        .alu_issue_op    (alu_issue_op),
        .alu_issue_a     (alu_issue_a),
        .alu_issue_b     (alu_issue_b),
        .mul_issue_valid (mul_issue_valid),
        .mul_issue_ready (mul_issue_ready),
        .mul_issue_tag   (mul_issue_tag),
        .mul_issue_a     (mul_issue_a),
        .mul_issue_b     (mul_issue_b),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_value       (cdb_value)
    );

endmodule

`default_nettype wire

// ==== test/tomasulo_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "tomasulo_cfg.svh"

module tomasulo_core_tb
    import tomasulo_pkg::*;
;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;
    localparam logic [6:0] F7_MUL  = 7'b0000001;
    localparam logic [6:0] OPCODE_LOAD = 7'b0000011;
    localparam int RANDOM_COUNT = 48;

    logic             clock;
    logic             reset;
    logic             instr_valid;
    logic             instr_ready;
    instr_word_u      instr;
    logic             cdb_valid;
    logic [4:0]       cdb_rd;
    logic [`XLEN-1:0] cdb_value;
    logic [4:0]       debug_index;
    logic [`XLEN-1:0] debug_value;
    logic             rs_busy;

    int               seed = 32'hf4a6;
    int               error_count = 0;
    int               broadcast_count = 0;
    int               write_count = 0;
    int               stall_count = 0;
    int               cycle_count = 0;
    int               cycle_limit = 0;
    int               burst_first;
    int               burst_last;
    logic [`XLEN-1:0] model_regs [`REG_COUNT];
    logic [31:0]      program_q [$];
    // Expected broadcasts as {rd, value}, searched by destination
    logic [36:0]      pending [$];

    tomasulo_core u_dut (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr       (instr),
        .cdb_valid   (cdb_valid),
        .cdb_rd      (cdb_rd),
        .cdb_value   (cdb_value),
        .debug_index (debug_index),
        .debug_value (debug_value),
        .rs_busy     (rs_busy)
    );

    always #2 clock = ~clock;

    function automatic logic [31:0] r_type_word(input logic [6:0] funct7,
                                                input logic [2:0] funct3,
                                                input logic [4:0] rd,
                                                input logic [4:0] rs1,
                                                input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, OPCODE_OP};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm,
                                                input logic [2:0] funct3,
                                                input logic [4:0] rd,
                                                input logic [4:0] rs1);
        return {imm, rs1, funct3, rd, OPCODE_OP_IMM};
    endfunction

    // Applies one instruction to the model in program order
    function automatic logic [`XLEN-1:0] golden_execute(input logic [31:0] word,
                                                        output logic writes);
        logic [6:0]       opcode;
        logic [6:0]       funct7;
        logic [2:0]       funct3;
        logic [4:0]       rd;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] result;
        opcode = word[6:0];
        rd     = word[11:7];
        funct3 = word[14:12];
        funct7 = word[31:25];
        a      = model_regs[word[19:15]];
        if (opcode == OPCODE_OP_IMM)
            b = {{(`XLEN-12){word[31]}}, word[31:20]};
        else
            b = model_regs[word[24:20]];
        writes = 1'b1;
        result = '0;
        if (opcode != OPCODE_OP && opcode != OPCODE_OP_IMM) begin
            writes = 1'b0;
        end else if (opcode == OPCODE_OP && funct7 == F7_MUL) begin
            if (funct3 == 3'b000)
                result = a * b;
            else
                writes = 1'b0;
        end else begin
            case (funct3)
                3'b000:  result = (opcode == OPCODE_OP && funct7 == F7_SUB) ? a - b : a + b;
                3'b001:  result = a << b[4:0];
                3'b010:  result = ($signed(a) < $signed(b)) ? 1 : 0;
                3'b100:  result = a ^ b;
                3'b101:  result = a >> b[4:0];
                3'b110:  result = a | b;
                3'b111:  result = a & b;
                default: writes = 1'b0;
            endcase
        end
        // x0 never changes, though its result still goes out on the CDB
        if (writes && rd != 5'd0)
            model_regs[rd] = result;
        return result;
    endfunction

    task automatic push_random_instruction();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        kind = $unsigned($random(seed)) % 14;
        rd   = 5'($unsigned($random(seed)) % 8);
        rs1  = 5'($unsigned($random(seed)) % 8);
        rs2  = 5'($unsigned($random(seed)) % 8);
        imm  = 12'($random(seed));
        case (kind)
            0:       program_q.push_back(r_type_word(F7_BASE, 3'b000, rd, rs1, rs2));
            1:       program_q.push_back(r_type_word(F7_SUB, 3'b000, rd, rs1, rs2));
            2:       program_q.push_back(r_type_word(F7_BASE, 3'b111, rd, rs1, rs2));
            3:       program_q.push_back(r_type_word(F7_BASE, 3'b110, rd, rs1, rs2));
            4:       program_q.push_back(r_type_word(F7_BASE, 3'b100, rd, rs1, rs2));
            5:       program_q.push_back(r_type_word(F7_BASE, 3'b001, rd, rs1, rs2));
            6:       program_q.push_back(r_type_word(F7_BASE, 3'b101, rd, rs1, rs2));
            7:       program_q.push_back(r_type_word(F7_BASE, 3'b010, rd, rs1, rs2));
            8, 9:    program_q.push_back(r_type_word(F7_MUL, 3'b000, rd, rs1, rs2));
            10:      program_q.push_back(i_type_word(imm, 3'b000, rd, rs1));
            11:      program_q.push_back(i_type_word(imm, 3'b010, rd, rs1));
            12:      program_q.push_back(i_type_word({7'd0, imm[4:0]}, 3'b101, rd, rs1));
            default: program_q.push_back({imm, rs1, 3'b010, rd, OPCODE_LOAD});
        endcase
    endtask

    task automatic build_program();
        // Seed a few source registers
        program_q.push_back(i_type_word(12'h123, 3'b000, 5'd1, 5'd0));
        program_q.push_back(i_type_word(12'hffb, 3'b000, 5'd2, 5'd0));
        program_q.push_back(i_type_word(12'h7ff, 3'b000, 5'd3, 5'd0));
        program_q.push_back(i_type_word(12'h003, 3'b000, 5'd4, 5'd0));
        // Independent ALU operations
        program_q.push_back(r_type_word(F7_BASE, 3'b000, 5'd10, 5'd1, 5'd2));
        program_q.push_back(r_type_word(F7_SUB, 3'b000, 5'd11, 5'd1, 5'd3));
        program_q.push_back(r_type_word(F7_BASE, 3'b111, 5'd12, 5'd2, 5'd3));
        program_q.push_back(r_type_word(F7_BASE, 3'b110, 5'd13, 5'd1, 5'd2));
        program_q.push_back(r_type_word(F7_BASE, 3'b100, 5'd14, 5'd2, 5'd3));
        program_q.push_back(r_type_word(F7_BASE, 3'b001, 5'd15, 5'd1, 5'd4));
        program_q.push_back(r_type_word(F7_BASE, 3'b101, 5'd16, 5'd2, 5'd4));
        program_q.push_back(r_type_word(F7_BASE, 3'b010, 5'd17, 5'd2, 5'd1));
        program_q.push_back(i_type_word(12'hf9c, 3'b000, 5'd18, 5'd3));
        // Dependent chain through ALU and multiplier
        program_q.push_back(i_type_word(12'h011, 3'b000, 5'd20, 5'd1));
        program_q.push_back(r_type_word(F7_MUL, 3'b000, 5'd21, 5'd20, 5'd2));
        program_q.push_back(r_type_word(F7_SUB, 3'b000, 5'd22, 5'd21, 5'd20));
        program_q.push_back(r_type_word(F7_MUL, 3'b000, 5'd23, 5'd22, 5'd22));
        program_q.push_back(r_type_word(F7_BASE, 3'b000, 5'd24, 5'd23, 5'd21));
        // Slow MUL then fast ADD to the same register
        program_q.push_back(r_type_word(F7_MUL, 3'b000, 5'd25, 5'd1, 5'd3));
        program_q.push_back(r_type_word(F7_BASE, 3'b000, 5'd25, 5'd1, 5'd3));
        program_q.push_back(r_type_word(F7_BASE, 3'b100, 5'd27, 5'd25, 5'd1));
        // Writes to x0 and a read of it
        program_q.push_back(i_type_word(12'h055, 3'b000, 5'd0, 5'd0));
        program_q.push_back(r_type_word(F7_BASE, 3'b000, 5'd0, 5'd1, 5'd3));
        program_q.push_back(r_type_word(F7_MUL, 3'b000, 5'd0, 5'd2, 5'd3));
        program_q.push_back(r_type_word(F7_BASE, 3'b000, 5'd28, 5'd0, 5'd1));
        // A load is taken and dropped
        program_q.push_back({12'h000, 5'd1, 3'b010, 5'd29, OPCODE_LOAD});
        // Multiply burst larger than the two multiply entries
        burst_first = program_q.size();
        program_q.push_back(r_type_word(F7_MUL, 3'b000, 5'd5, 5'd1, 5'd2));
        program_q.push_back(r_type_word(F7_MUL, 3'b000, 5'd6, 5'd2, 5'd3));
        program_q.push_back(r_type_word(F7_MUL, 3'b000, 5'd7, 5'd3, 5'd4));
        program_q.push_back(r_type_word(F7_MUL, 3'b000, 5'd8, 5'd1, 5'd1));
        program_q.push_back(r_type_word(F7_MUL, 3'b000, 5'd9, 5'd4, 5'd4));
        burst_last = program_q.size() - 1;
        for (int n = 0; n < RANDOM_COUNT; n++)
            push_random_instruction();
    endtask

    // Holds the word until the DUT takes it, then updates the model
    task automatic drive_instruction(input logic [31:0] word, input logic in_burst);
        logic [`XLEN-1:0] result;
        logic             writes;
        @(negedge clock);
        instr_valid = 1'b1;
        instr       = instr_word_u'(word);
        #1;
        while (instr_ready !== 1'b1) begin
            if (in_burst)
                stall_count++;
            @(negedge clock);
            #1;
        end
        @(posedge clock);
        result = golden_execute(word, writes);
        if (writes) begin
            pending.push_back({word[11:7], result});
            write_count++;
        end
    endtask

    // Every CDB pulse must match a write still in flight for that rd
    always @(negedge clock) begin
        int match;
        int oldest;
        if (reset === 1'b0 && cdb_valid === 1'b1) begin
            broadcast_count++;
            match  = -1;
            oldest = -1;
            for (int i = 0; i < pending.size(); i++) begin
                if (oldest < 0 && pending[i][36:32] == cdb_rd)
                    oldest = i;
                if (match < 0 && pending[i] == {cdb_rd, cdb_value})
                    match = i;
            end
            if (match >= 0) begin
                pending.delete(match);
            end else if (oldest >= 0) begin
                error_count++;
                $display("[FAIL] %0t cdb_value for rd %0d: expected %h, got %h",
                         $time, cdb_rd, pending[oldest][31:0], cdb_value);
            end else begin
                error_count++;
                $display("[FAIL] %0t cdb_rd: expected a destination in flight, got %0d",
                         $time, cdb_rd);
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        debug_index = '0;
        for (int r = 0; r < `REG_COUNT; r++)
            model_regs[r] = '0;
        build_program();
        cycle_limit = program_q.size() * (`MUL_LATENCY + 4) + 50;

        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // A legal ALU word without valid shows the free ALU entries
        instr = instr_word_u'(r_type_word(F7_BASE, 3'b000, 5'd0, 5'd0, 5'd0));
        #1;
        if (rs_busy !== 1'b0) begin
            error_count++;
            $display("[FAIL] %0t rs_busy: expected 0, got %b", $time, rs_busy);
        end
        if (cdb_valid !== 1'b0) begin
            error_count++;
            $display("[FAIL] %0t cdb_valid: expected 0, got %b", $time, cdb_valid);
        end
        if (instr_ready !== 1'b1) begin
            error_count++;
            $display("[FAIL] %0t instr_ready for ALU: expected 1, got %b",
                     $time, instr_ready);
        end
        @(negedge clock);
        instr = instr_word_u'(r_type_word(F7_MUL, 3'b000, 5'd0, 5'd0, 5'd0));
        #1;
        if (instr_ready !== 1'b1) begin
            error_count++;
            $display("[FAIL] %0t instr_ready for MUL: expected 1, got %b",
                     $time, instr_ready);
        end

        for (int n = 0; n < program_q.size(); n++)
            drive_instruction(program_q[n], n >= burst_first && n <= burst_last);
        @(negedge clock);
        instr_valid = 1'b0;

        // Drain, then read back the architectural registers
        while (rs_busy !== 1'b0)
            @(negedge clock);
        for (int r = 0; r < `REG_COUNT; r++) begin
            @(negedge clock);
            debug_index = 5'(r);
            #1;
            if (debug_value !== model_regs[r]) begin
                error_count++;
                $display("[FAIL] %0t debug_value x%0d: expected %h, got %h",
                         $time, r, model_regs[r], debug_value);
            end
        end

        if (pending.size() != 0) begin
            error_count++;
            $display("%0d expected results never appeared on the CDB", pending.size());
        end
        if (broadcast_count != write_count) begin
            error_count++;
            $display("Saw %0d CDB broadcasts for %0d executed instructions",
                     broadcast_count, write_count);
        end
        if (stall_count == 0) begin
            error_count++;
            $display("instr_ready never dropped during the multiply burst");
        end

        $display("Run done: %0d errors, %0d instructions, %0d broadcasts, %0d cycles",
                 error_count, program_q.size(), broadcast_count, cycle_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tomasulo_core.f ====
+incdir+include
source/tomasulo_pkg.sv
source/dispatch_stage.sv
source/reservation_station.sv
source/execute_units.sv
source/tomasulo_core.sv
test/tomasulo_core_tb.sv

// ==== Bender.yml ====
package:
  name: tomasulo_core

export_include_dirs:
  - include

sources:
  - files:
      - source/tomasulo_pkg.sv
      - source/dispatch_stage.sv
      - source/reservation_station.sv
      - source/execute_units.sv
      - source/tomasulo_core.sv
  - target: test
    files:
      - test/tomasulo_core_tb.sv
